// ==== common/filter_pkg.sv ====
`default_nettype none

package filter_pkg;

	// channels 0 and 1 on the first ADC, 2 and 3 on the second
	localparam int NUM_CHANNELS = 4;

	// ADC sample format
	localparam int ADC_WIDTH = 16;
	localparam int ADC_DROP_BITS = 4; // noise bits below the top 12

	// filter input is the top 12 bits with a zero msb on top
	localparam int FIR_IN_WIDTH = ADC_WIDTH - ADC_DROP_BITS + 1;

	localparam int FIR_TAPS = 4;
	localparam int FIR_COEF_WIDTH = 3; // enough for +/-3
	localparam int FIR_OUT_WIDTH = 16; // |sum| stays below 2^14

	// output timing
	localparam int SIGN_DELAY = 2;
	localparam int STRETCH_LEN = 4; // data_en lasts STRETCH_LEN + 1 cycles

	typedef logic [ADC_WIDTH-1:0] adc_word_t;

	typedef logic [FIR_IN_WIDTH-1:0] fir_in_t;

	typedef logic signed [FIR_OUT_WIDTH-1:0] fir_out_t;

	typedef logic [FIR_OUT_WIDTH-1:0] fir_mag_t;

	typedef logic signed [FIR_COEF_WIDTH-1:0] fir_coef_t;

	// newest sample first, antisymmetric so dc gives zero
	localparam fir_coef_t FIR_COEFS [FIR_TAPS] = '{
		3'sd3,
		3'sd1,
		-3'sd1,
		-3'sd3
	};

endpackage

`default_nettype wire

// ==== dv/filter_model.svh ====
`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

// filter input, the ADC word without its noise bits
function automatic int model_sample(input adc_word_t word);
	return int'(word >> ADC_DROP_BITS);
endfunction

// taps[0] is the newest sample
function automatic int model_fir(input int taps [FIR_TAPS]);
	int sum;
	sum = 0;
	for (int i = 0; i < FIR_TAPS; i++)
	begin
		sum = sum + taps[i] * int'(FIR_COEFS[i]);
	end
	return sum;
endfunction

function automatic int model_magnitude(input int value);
	if (value < 0)
		return -value;
	return value;
endfunction

function automatic logic model_sign(input int value);
	return value < 0;
endfunction

`endif

// ==== dv/filter_bank_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module filter_bank_tb;

	import filter_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CHECK_CYCLES = 3;
	localparam int NUM_ROWS = 16;
	localparam int ROW_CYCLES = 20;
	localparam int EN_HIGH_CYCLES = 3;
	localparam int RAW_EN_CYCLE = 5; // drive edge plus 4 cycles through the channel
	localparam int SIGN_CYCLE = RAW_EN_CYCLE + SIGN_DELAY;
	localparam int WATCHDOG_NS =
		2 * CLK_PERIOD * (RESET_CYCLES + IDLE_CHECK_CYCLES + NUM_ROWS * ROW_CYCLES);

	logic clk;
	logic reset;
	adc_word_t adc_data [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] adc_en;
	fir_out_t raw_data [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] raw_en;
	fir_mag_t mag_data [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] sign;
	logic [NUM_CHANNELS-1:0] data_en;

	// one row per enable burst
	adc_word_t stim_words [NUM_ROWS][NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] stim_mask [NUM_ROWS];
	int exp_raw [NUM_ROWS][NUM_CHANNELS]; // held result after the row

	logic [31:0] rng_state;
	int check_count;
	int error_count;

	`include "filter_model.svh"

	filter_bank dut0
	(
		.clk      (clk),
		.reset    (reset),
		.adc_data (adc_data),
		.adc_en   (adc_en),
		.raw_data (raw_data),
		.raw_en   (raw_en),
		.mag_data (mag_data),
		.sign     (sign),
		.data_en  (data_en)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t",
				name, got, expected, $time);
		end
	endtask

	task automatic build_table();
		int hist [NUM_CHANNELS][FIR_TAPS];
		int held [NUM_CHANNELS];
		int taps [FIR_TAPS];
		rng_state = 32'd56492;
		for (int row = 0; row < NUM_ROWS; row++)
		begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
			begin
				rng_state = lcg_next(rng_state);
				stim_words[row][ch] = rng_state[31:16];
			end
			rng_state = lcg_next(rng_state);
			stim_mask[row] = rng_state[31:28];
		end
		// full scale, zero and one lsb first, all channels on
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
		begin
			stim_words[0][ch] = 16'hFFFF;
			stim_words[1][ch] = 16'h0000;
			stim_words[2][ch] = 16'h0010;
		end
		stim_mask[0] = '1;
		stim_mask[1] = '1;
		stim_mask[2] = '1;
		stim_words[3][0] = 16'hFFFF;
		stim_words[3][1] = 16'h0000;
		stim_words[3][2] = 16'hFFFF;
		stim_words[3][3] = 16'h0010;
		stim_mask[3] = 4'b0101;

		for (int ch = 0; ch < NUM_CHANNELS; ch++)
		begin
			held[ch] = 0;
			for (int i = 0; i < FIR_TAPS; i++)
				hist[ch][i] = 0;
		end
		for (int row = 0; row < NUM_ROWS; row++)
		begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
			begin
				if (stim_mask[row][ch])
				begin
					for (int i = FIR_TAPS - 1; i > 0; i--)
						hist[ch][i] = hist[ch][i-1];
					hist[ch][0] = model_sample(stim_words[row][ch]);
					for (int i = 0; i < FIR_TAPS; i++)
						taps[i] = hist[ch][i];
					held[ch] = model_fir(taps);
				end
				exp_raw[row][ch] = held[ch]; // masked off channels keep the old value
			end
		end
	endtask

	task automatic check_idle();
		for (int c = 0; c < IDLE_CHECK_CYCLES; c++)
		begin
			@(negedge clk);
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
			begin
				check_value($sformatf("raw_en[%0d]", ch), raw_en[ch], 0);
				check_value($sformatf("data_en[%0d]", ch), data_en[ch], 0);
				check_value($sformatf("raw_data[%0d]", ch), int'(raw_data[ch]), 0);
				check_value($sformatf("mag_data[%0d]", ch), mag_data[ch], 0);
			end
		end
	endtask

	task automatic apply_row(input int row);
		int pulses [NUM_CHANNELS];
		int first_pulse [NUM_CHANNELS];
		int expected;
		logic want_en;
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
		begin
			pulses[ch] = 0;
			first_pulse[ch] = -1;
		end
		for (int c = 0; c < ROW_CYCLES; c++)
		begin
			@(posedge clk);
			if (c == 0)
			begin
				for (int ch = 0; ch < NUM_CHANNELS; ch++)
					adc_data[ch] <= stim_words[row][ch];
				adc_en <= stim_mask[row];
			end
			else if (c == EN_HIGH_CYCLES)
				adc_en <= '0;
			@(negedge clk); // outputs settled here
			for (int ch = 0; ch < NUM_CHANNELS; ch++)
			begin
				expected = exp_raw[row][ch];
				if (raw_en[ch])
				begin
					pulses[ch]++;
					if (first_pulse[ch] < 0)
						first_pulse[ch] = c;
					check_value($sformatf("raw_data[%0d]", ch), int'(raw_data[ch]), expected);
					check_value($sformatf("mag_data[%0d]", ch), mag_data[ch],
						model_magnitude(expected));
				end
				want_en = stim_mask[row][ch] && c >= RAW_EN_CYCLE &&
					c <= RAW_EN_CYCLE + STRETCH_LEN;
				check_value($sformatf("data_en[%0d]", ch), data_en[ch], want_en);
				if (c == SIGN_CYCLE)
					check_value($sformatf("sign[%0d]", ch), sign[ch], model_sign(expected));
			end
		end
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
		begin
			check_value($sformatf("raw_en[%0d] pulse count", ch), pulses[ch],
				stim_mask[row][ch]);
			if (stim_mask[row][ch])
				check_value($sformatf("raw_en[%0d] cycle", ch), first_pulse[ch], RAW_EN_CYCLE);
			check_value($sformatf("raw_data[%0d] held", ch), int'(raw_data[ch]),
				exp_raw[row][ch]);
			check_value($sformatf("mag_data[%0d] held", ch), mag_data[ch],
				model_magnitude(exp_raw[row][ch]));
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		adc_en = '0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++)
			adc_data[ch] = '0;
		check_count = 0;
		error_count = 0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		check_idle();
		for (int row = 0; row < NUM_ROWS; row++)
			apply_row(row);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// whole run with a factor of two margin
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the stimulus loop did not finish within %0d ns", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== fir_channel/fir_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_channel
(
	input logic clk,
	input logic reset,
	input filter_pkg::adc_word_t adc_data,
	input logic adc_en,
	output filter_pkg::fir_out_t raw_data,
	output logic raw_en,
	output filter_pkg::fir_mag_t mag_data,
	output logic sign,
	output logic data_en
);

	import filter_pkg::*;

	logic [2:0] en_sync; // en_sync[0] takes the raw level
	logic sample_strobe;
	fir_in_t sample;
	fir_out_t result;
	logic result_valid;

	// adc enable comes from the converter side, resync before edge detect
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			en_sync <= '0;
			sample_strobe <= 1'b0;
		end
		else
		begin
			en_sync <= {en_sync[1:0], adc_en};
			sample_strobe <= en_sync[1] & ~en_sync[2]; // rising edge only
		end
	end

	// top 12 bits, zero msb keeps the input non-negative
	assign sample = {1'b0, adc_data[ADC_WIDTH-1:ADC_DROP_BITS]};

	fir_filter u_fir
	(
		.clk           (clk),
		.reset         (reset),
		.sample_strobe (sample_strobe),
		.sample        (sample),
		.result        (result),
		.result_valid  (result_valid)
	);

	output_shaper u_shaper
	(
		.clk          (clk),
		.reset        (reset),
		.result       (result),
		.result_valid (result_valid),
		.raw_data     (raw_data),
		.raw_en       (raw_en),
		.mag_data     (mag_data),
		.sign         (sign),
		.data_en      (data_en)
	);

endmodule

`default_nettype wire

// ==== fir_channel/fir_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_filter
(
	input logic clk,
	input logic reset,
	input logic sample_strobe,
	input filter_pkg::fir_in_t sample,
	output filter_pkg::fir_out_t result,
	output logic result_valid
);

	import filter_pkg::*;

	fir_in_t hist [FIR_TAPS-1]; // hist[0] is the previous sample
	fir_in_t window [FIR_TAPS]; // new sample followed by history
	fir_out_t tap_term [FIR_TAPS];
	fir_out_t acc;

	// the incoming sample already counts as tap 0
	always_comb
	begin
		window[0] = sample;
		for (int i = 1; i < FIR_TAPS; i++)
		begin
			window[i] = hist[i-1];
		end
	end

	always_comb
	begin
		for (int i = 0; i < FIR_TAPS; i++)
		begin
			tap_term[i] = fir_out_t'(window[i]) * fir_out_t'(FIR_COEFS[i]); // zero-ext sample
		end
	end

	always_comb
	begin
		acc = '0;
		for (int i = 0; i < FIR_TAPS; i++)
		begin
			acc = acc + tap_term[i];
		end
	end

	// history only moves on a strobe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < FIR_TAPS-1; i++)
			begin
				hist[i] <= '0;
			end
		end
		else if (sample_strobe)
		begin
			hist[0] <= sample;
			for (int i = 1; i < FIR_TAPS-1; i++)
			begin
				hist[i] <= hist[i-1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			if (sample_strobe)
				result <= acc; // held between strobes
			result_valid <= sample_strobe;
		end
	end

endmodule

`default_nettype wire

// ==== fir_channel/output_shaper.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_shaper
(
	input logic clk,
	input logic reset,
	input filter_pkg::fir_out_t result,
	input logic result_valid,
	output filter_pkg::fir_out_t raw_data,
	output logic raw_en,
	output filter_pkg::fir_mag_t mag_data,
	output logic sign,
	output logic data_en
);

	import filter_pkg::*;

	fir_mag_t mag_next;
	logic [STRETCH_LEN-1:0] valid_hist; // valid_hist[0] is one cycle old
	logic [SIGN_DELAY-1:0] sign_dly;

	// abs value, msb forced low
	always_comb
	begin
		if (result[FIR_OUT_WIDTH-1])
			mag_next = {1'b0, ~(result[FIR_OUT_WIDTH-2:0] - 1'b1)};
		else
			mag_next = fir_mag_t'(result);
	end

	// raw and magnitude hold until the next filter output
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			raw_data <= '0;
			mag_data <= '0;
		end
		else if (result_valid)
		begin
			raw_data <= result;
			mag_data <= mag_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			raw_en <= 1'b0;
		else
			raw_en <= result_valid;
	end

	// stretch valid so slow consumers see it
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_hist <= '0;
			data_en <= 1'b0;
		end
		else
		begin
			valid_hist <= {valid_hist[STRETCH_LEN-2:0], result_valid};
			data_en <= result_valid | (|valid_hist);
		end
	end

	// sign trails the captured result
	always_ff @(posedge clk)
	begin
		if (reset)
			sign_dly <= '0;
		else
			sign_dly <= {sign_dly[SIGN_DELAY-2:0], raw_data[FIR_OUT_WIDTH-1]};
	end

	assign sign = sign_dly[SIGN_DELAY-1];

endmodule

`default_nettype wire

// ==== hw/filter_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module filter_bank
(
	input logic clk,
	input logic reset,

	// index 0,1 first ADC, 2,3 second ADC
	input filter_pkg::adc_word_t adc_data [filter_pkg::NUM_CHANNELS],
	input logic [filter_pkg::NUM_CHANNELS-1:0] adc_en,

	output filter_pkg::fir_out_t raw_data [filter_pkg::NUM_CHANNELS],
	output logic [filter_pkg::NUM_CHANNELS-1:0] raw_en,
	output filter_pkg::fir_mag_t mag_data [filter_pkg::NUM_CHANNELS],
	output logic [filter_pkg::NUM_CHANNELS-1:0] sign,
	output logic [filter_pkg::NUM_CHANNELS-1:0] data_en
);

	import filter_pkg::*;

	genvar ch;

	// channels are independent, no shared state
	generate
		for (ch = 0; ch < NUM_CHANNELS; ch++)
		begin : g_channel
			fir_channel u_channel
			(
				.clk      (clk),
				.reset    (reset),
				.adc_data (adc_data[ch]),
				.adc_en   (adc_en[ch]),
				.raw_data (raw_data[ch]),
				.raw_en   (raw_en[ch]),
				.mag_data (mag_data[ch]),
				.sign     (sign[ch]),
				.data_en  (data_en[ch])
			);
		end
	endgenerate

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the filter_bank testbench with Verilator.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=sim_filter_bank
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
	-f vlog.f \
	--top-module filter_bank_tb \
	-Mdir "${BUILD_DIR}" \
	-o "${SIM_BIN}"

"./${BUILD_DIR}/${SIM_BIN}" | tee "${LOG_FILE}"

if grep -q "Some tests failed" "${LOG_FILE}"; then
	echo "Simulation reported failures, see ${LOG_FILE}"
	exit 1
fi
echo "Simulation finished without failures"

// ==== vlog.f ====
+incdir+dv
common/filter_pkg.sv
fir_channel/fir_filter.sv
fir_channel/output_shaper.sv
fir_channel/fir_channel.sv
hw/filter_bank.sv
dv/filter_bank_tb.sv
